//--- tb.f
verilog/sifhPkg.sv
verilog/wbRegPkg.sv
verilog/sifhWindow.sv
verilog/sifhHistogram.sv
verilog/sifhFrameCtrl.sv
verilog/sifhRegs.sv
verilog/sifhTop.sv
tests/sifhTb.sv

//--- run.sh
#!/bin/sh
# Build and run the SiFH testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module sifhTb -f tb.f -o sifhSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sifhSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tests/sifhTb.sv
/*
 * SiFH testbench
 * Streams LFSR timestamps through two frames and checks results against a model
 */
`timescale 1ns/1ps

module sifhTb;
    import sifhPkg::*;
    import wbRegPkg::*;

    localparam logic [15:0] SEED        = 16'd18958;
    localparam int          CYCLE_LIMIT = 4000;  // Two frames plus bus traffic need about 500

    logic          clk;
    logic          combin_res;
    logic          sampleValid;
    logic [NP-1:0] sampleData;
    logic          sampleReady;
    wbReqT         wbReq;
    wbRspT         wbRsp;

    logic [15:0]   lfsr;
    logic [NP-1:0] acceptedQ [$];  // Samples the DUT took in order
    int            frameAcq;
    int            cycleCount;

    sifhTop u_sifhTop (
        .clk        (clk),
        .combin_res (combin_res),
        .sampleValid(sampleValid),
        .sampleData (sampleData),
        .sampleReady(sampleReady),
        .wbReq      (wbReq),
        .wbRsp      (wbRsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // ****************************************
    // Failure reporting and watchdog
    // ****************************************
    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp)
            else failNow($sformatf("error %s got 0x%02h expected 0x%02h", name, got, exp));
    endtask

    initial begin
        cycleCount = 0;
        forever begin
            @(posedge clk);
            cycleCount++;
            assert (cycleCount < CYCLE_LIMIT) else failNow("timeout, the run hit its cycle limit");
        end
    end

    // ****************************************
    // Stimulus
    // ****************************************
    // 16 bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic lfsrBit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] randBits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsrBit()};  // One step per bit
        end
        return v;
    endfunction

    // Mostly jitter around the target over a flat background
    function automatic logic [NP-1:0] makeTimestamp(input logic [NP-1:0] target);
        int v;
        if (randBits(3) < 8'd5) begin
            v = int'(target) + int'(randBits(3)) - 3;
            if (v < 0) v = 0;      // Clamp to timestamp range
            if (v > 255) v = 255;
        end else begin
            v = int'(randBits(8));
        end
        return NP'(v);
    endfunction

    // Offer one sample and hold it until the DUT takes it
    task automatic pushSample(input logic [NP-1:0] ts, input bit holdValid);
        bit got;
        int waits;
        got         = 1'b0;
        waits       = 0;
        sampleValid = 1'b1;
        sampleData  = ts;
        while (!got) begin
            @(negedge clk);
            got = sampleReady;  // Taken at the coming edge
            @(posedge clk);
            #10;
            waits++;
            assert (waits < 50) else failNow("sample stream stalled far beyond the drain");
        end
        acceptedQ.push_back(ts);
        if (!holdValid) begin
            sampleValid = 1'b0;   // One idle cycle between samples
            @(posedge clk);
            #10;
        end
    endtask

    // Wishbone classic access with its ack one cycle after the request
    task automatic wbAccess(input logic we, input logic [WB_ADR_W-1:0] adr,
                            input logic [7:0] wdat, output logic [7:0] rdat);
        wbReq = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(negedge clk);
        assert (!wbRsp.ack) else failNow("wishbone ack came before the request was seen");
        @(negedge clk);
        assert (wbRsp.ack) else failNow("wishbone ack missing one cycle after the request");
        rdat = wbRsp.dat;
        @(posedge clk);
        #10;
        wbReq = '0;
        @(negedge clk);
        assert (!wbRsp.ack) else failNow("wishbone ack lasted more than one cycle");
        @(posedge clk);
        #10;
    endtask

    task automatic wbWrite(input logic [WB_ADR_W-1:0] adr, input logic [7:0] dat);
        logic [7:0] unused;
        wbAccess(1'b1, adr, dat, unused);
    endtask

    task automatic wbRead(input logic [WB_ADR_W-1:0] adr, output logic [7:0] dat);
        wbAccess(1'b0, adr, 8'h00, dat);
    endtask

    // Disable mid frame, offer a sample that must not be taken, then resume
    task automatic pauseStream();
        logic [7:0] rd;
        sampleValid = 1'b0;
        wbWrite(REG_CTRL, 8'h00);
        sampleValid = 1'b1;
        sampleData  = 8'h77;
        repeat (20) begin
            @(negedge clk);
            assert (!sampleReady) else failNow("sampleReady went high while disabled");
            @(posedge clk);
            #10;
        end
        sampleValid = 1'b0;
        wbRead(REG_STATUS, rd);
        checkByte("STATUS", rd, 8'h01);  // Frame count frozen
        wbWrite(REG_CTRL, 8'h01);
    endtask

    // Coarse then fine pass with pixel order fixed by the stream position
    task automatic runFrame(input logic [PIXELS-1:0][NP-1:0] targets, input int acq,
                            input bit holdValid, input int pauseAt);
        int p;
        acceptedQ.delete();
        frameAcq = acq;
        for (int i = 0; i < 2 * acq * PIXELS * SAMPLES; i++) begin
            if (i == pauseAt) pauseStream();
            p = (i / SAMPLES) % PIXELS;
            pushSample(makeTimestamp(targets[p]), holdValid);
        end
        sampleValid = 1'b0;
    endtask

    // ****************************************
    // Reference model and checks
    // ****************************************
    task automatic predictFrame(output resultT exp);
        int cnt [PIXELS][BINS];
        int pkBin [PIXELS];
        int pkCnt [PIXELS];
        int start [PIXELS];
        int perPass;
        int p;
        int b;
        int ts;
        int centre;
        perPass = frameAcq * PIXELS * SAMPLES;
        for (int q = 0; q < PIXELS; q++) start[q] = 0;
        for (int ps = 0; ps < 2; ps++) begin
            for (int q = 0; q < PIXELS; q++) begin
                pkBin[q] = 0;  // Fresh histogram each pass
                pkCnt[q] = 0;
                for (int k = 0; k < BINS; k++) cnt[q][k] = 0;
            end
            for (int i = ps * perPass; i < (ps + 1) * perPass; i++) begin
                ts = int'(acceptedQ[i]);
                p  = (i / SAMPLES) % PIXELS;
                if (ps == 0)
                    b = ts >> (NP - NB);               // Coarse rule on the upper bits
                else if (ts >= start[p] && ts <= start[p] + BINS - 1)
                    b = ts - start[p];
                else
                    b = -1;                            // Outside the fine window
                if (b >= 0) begin
                    if (cnt[p][b] < 255) cnt[p][b]++;
                    if (cnt[p][b] > pkCnt[p]) begin    // Ties keep the first bin
                        pkCnt[p] = cnt[p][b];
                        pkBin[p] = b;
                    end
                end
            end
            if (ps == 0) begin
                for (int q = 0; q < PIXELS; q++) begin
                    centre = pkBin[q] * 16;
                    if (centre < HALF_WIN) start[q] = 0;
                    else if (centre + HALF_WIN > 255) start[q] = 240;
                    else start[q] = centre - HALF_WIN;
                end
            end
        end
        for (int q = 0; q < PIXELS; q++) exp[q] = NP'(pkBin[q] + start[q]);
    endtask

    task automatic waitDone();
        logic [7:0] rd;
        int         polls;
        rd    = '0;
        polls = 0;
        while (!rd[7] && polls < 40) begin
            wbRead(REG_STATUS, rd);
            polls++;
        end
        assert (rd[7]) else failNow("done flag never set after the frame");
    endtask

    task automatic checkResults();
        resultT     exp;
        logic [7:0] rd;
        predictFrame(exp);
        for (int p = 0; p < PIXELS; p++) begin
            wbRead(WB_ADR_W'(int'(REG_RESULT0) + p), rd);
            checkByte($sformatf("RESULT%0d", p), rd, exp[p]);
        end
    endtask

    // ****************************************
    // Test sequence
    // ****************************************
    initial begin : mainSeq
        logic [7:0] rd;
        combin_res  = 1'b0;
        sampleValid = 1'b0;
        sampleData  = '0;
        wbReq       = '0;
        frameAcq    = 1;
        lfsr        = SEED;
        repeat (5) @(posedge clk);
        #10;
        combin_res = 1'b1;
        @(negedge clk);
        assert (!sampleReady && !wbRsp.ack) else failNow("handshake outputs high after reset");
        @(posedge clk);
        #10;

        // Reset values
        wbRead(REG_CTRL, rd);
        checkByte("CTRL", rd, 8'h00);
        wbRead(REG_ACQNUM, rd);
        checkByte("ACQNUM", rd, 8'h01);
        wbRead(REG_STATUS, rd);
        checkByte("STATUS", rd, 8'h00);

        // Frame 1 with edge targets and valid held through the drains
        wbWrite(REG_ACQNUM, 8'd2);
        wbWrite(REG_CTRL, 8'h01);
        runFrame({8'd249, 8'd170, 8'd90, 8'd4}, 2, 1'b1, -1);
        waitDone();
        checkResults();
        wbRead(REG_STATUS, rd);
        checkByte("STATUS", rd, 8'h81);
        wbWrite(REG_STATUS, 8'h5a);
        wbRead(REG_STATUS, rd);
        checkByte("STATUS", rd, 8'h01);  // Done cleared

        // Frame 2 with new targets and a pause in the coarse pass
        runFrame({8'd15, 8'd210, 8'd130, 8'd40}, 2, 1'b0, 24);
        waitDone();
        checkResults();
        wbRead(REG_STATUS, rd);
        checkByte("STATUS", rd, 8'h82);
        wbWrite(REG_STATUS, 8'h00);
        wbRead(REG_STATUS, rd);
        checkByte("STATUS", rd, 8'h02);

        $display("all tests passed");
        $finish;
    end

endmodule

//--- verilog/sifhTop.sv
/*
 * SiFH timing histogram engine, top level
 * Frame controller, window filter, histogram and Wishbone register block
 */
`timescale 1ns/1ps

module sifhTop (
    input  logic            clk,
    input  logic            combin_res,
    input  logic            sampleValid,
    input  logic [7:0]      sampleData,
    output logic            sampleReady,
    input  wbRegPkg::wbReqT wbReq,
    output wbRegPkg::wbRspT wbRsp
);
    import sifhPkg::*;

    logic                take;
    logic [1:0]          pixel;
    passE                pass;
    logic                passEnd;
    logic                enable;
    logic [7:0]          acqNum;
    sampleT              sample;
    binReqT              binReq;
    peakT [PIXELS-1:0]   peak;
    resultT              result;
    logic                resultLoad;

    // Pixel index comes from the counters, not the stream
    assign sample = '{timestamp: sampleData, pixel: pixel};

    sifhFrameCtrl u_sifhFrameCtrl (
        .clk        (clk),
        .combin_res (combin_res),
        .sampleValid(sampleValid),
        .enable     (enable),
        .acqNum     (acqNum),
        .sampleReady(sampleReady),
        .take       (take),
        .pixel      (pixel),
        .pass       (pass),
        .passEnd    (passEnd)
    );

    sifhWindow u_sifhWindow (
        .clk        (clk),
        .combin_res (combin_res),
        .take       (take),
        .sample     (sample),
        .pass       (pass),
        .passEnd    (passEnd),
        .coarsePeak (peak),      // Same histogram serves both passes
        .finePeak   (peak),
        .binReq     (binReq),
        .result     (result),
        .resultLoad (resultLoad)
    );

    sifhHistogram u_sifhHistogram (
        .clk        (clk),
        .combin_res (combin_res),
        .binReq     (binReq),
        .passEnd    (passEnd),
        .peak       (peak)
    );

    sifhRegs u_sifhRegs (
        .clk        (clk),
        .combin_res (combin_res),
        .wbReq      (wbReq),
        .wbRsp      (wbRsp),
        .result     (result),
        .resultLoad (resultLoad),
        .enable     (enable),
        .acqNum     (acqNum)
    );

endmodule

//--- verilog/sifhRegs.sv
/*
 * SiFH register block
 * Wishbone classic slave for control, status, frame count and results
 */
`timescale 1ns/1ps

module sifhRegs (
    input  logic            clk,
    input  logic            combin_res,
    input  wbRegPkg::wbReqT wbReq,
    output wbRegPkg::wbRspT wbRsp,
    input  sifhPkg::resultT result,
    input  logic            resultLoad,
    output logic            enable,
    output logic [7:0]      acqNum
);
    import sifhPkg::*;
    import wbRegPkg::*;

    logic                done;
    logic [6:0]          frameCnt;  // Wraps
    resultT              resultQ;
    logic                access;
    regAdrE              adr;
    logic [WB_DAT_W-1:0] rdData;

    assign access = wbReq.cyc && wbReq.stb && !wbRsp.ack;  // One ack per access
    assign adr    = regAdrE'(wbReq.adr);

    // ****************************************
    // Read mux
    // ****************************************
    always_comb begin
        case (adr)
            REG_CTRL:    rdData = {7'd0, enable};
            REG_ACQNUM:  rdData = acqNum;
            REG_STATUS:  rdData = {done, frameCnt};
            REG_RESULT0: rdData = resultQ[0];
            REG_RESULT1: rdData = resultQ[1];
            REG_RESULT2: rdData = resultQ[2];
            REG_RESULT3: rdData = resultQ[3];
            default:     rdData = '0;  // Unmapped reads as zero
        endcase
    end

    // ****************************************
    // Register updates
    // ****************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wbRsp    <= '0;
            enable   <= 1'b0;
            acqNum   <= 8'd1;
            done     <= 1'b0;
            frameCnt <= '0;
            resultQ  <= '0;
        end else begin
            wbRsp.ack <= access;
            wbRsp.dat <= rdData;  // Data valid with ack
            if (access && wbReq.we) begin
                case (adr)
                    REG_CTRL:   enable <= wbReq.dat[0];
                    REG_ACQNUM: begin
                        if (wbReq.dat != '0) acqNum <= wbReq.dat;  // Zero ignored
                    end
                    REG_STATUS: done <= 1'b0;  // Any value clears done
                    default: ;
                endcase
            end
            // New frame result, wins over a done clear
            if (resultLoad) begin
                resultQ  <= result;
                frameCnt <= frameCnt + 7'd1;
                done     <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/sifhFrameCtrl.sv
/*
 * SiFH frame controller
 * Counts samples, pixels and acquisitions, stalls the stream and sequences passes
 */
`timescale 1ns/1ps

module sifhFrameCtrl (
    input  logic          clk,
    input  logic          combin_res,
    input  logic          sampleValid,
    input  logic          enable,
    input  logic [7:0]    acqNum,
    output logic          sampleReady,
    output logic          take,
    output logic [1:0]    pixel,
    output sifhPkg::passE pass,
    output logic          passEnd
);
    import sifhPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } stateE;

    stateE      state;
    logic [1:0] sampleCnt;   // Sample within pixel
    logic [7:0] acqCnt;      // Acquisition within pass
    logic [1:0] drainCnt;
    logic       lastSample;

    assign sampleReady = (state == RUN) && enable;
    assign take        = sampleValid && sampleReady;
    assign lastSample  = (sampleCnt == 2'(SAMPLES - 1)) && (pixel == 2'(PIXELS - 1)) &&
                         ({1'b0, acqCnt} + 9'd1 >= {1'b0, acqNum});
    assign passEnd     = (state == DRAIN) && (drainCnt == 2'(sifhPkg::DRAIN - 1));

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state     <= IDLE;
            sampleCnt <= '0;
            pixel     <= '0;
            acqCnt    <= '0;
            drainCnt  <= '0;
            pass      <= PASS_COARSE;
        end else begin
            case (state)
                IDLE: begin
                    if (enable) state <= RUN;  // Counters resume where they stopped
                end
                RUN: begin
                    if (take) begin
                        if (sampleCnt == 2'(SAMPLES - 1)) begin
                            sampleCnt <= '0;
                            if (pixel == 2'(PIXELS - 1)) begin
                                pixel  <= '0;
                                acqCnt <= lastSample ? 8'd0 : acqCnt + 8'd1;
                            end else begin
                                pixel <= pixel + 2'd1;
                            end
                        end else begin
                            sampleCnt <= sampleCnt + 2'd1;
                        end
                        if (lastSample) begin
                            state    <= DRAIN;  // Let the pipeline retire
                            drainCnt <= '0;
                        end
                    end else if (!enable) begin
                        state <= IDLE;
                    end
                end
                DRAIN: begin
                    if (passEnd) begin
                        drainCnt <= '0;
                        state    <= enable ? RUN : IDLE;
                        pass     <= (pass == PASS_COARSE) ? PASS_FINE : PASS_COARSE;
                    end else begin
                        drainCnt <= drainCnt + 2'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- verilog/sifhHistogram.sv
/*
 * SiFH histogram builder with peak tracking
 * Lazily cleared bin memory, two stage read-modify-write, per pixel running peak
 */
`timescale 1ns/1ps

module sifhHistogram (
    input  logic                                clk,
    input  logic                                combin_res,
    input  sifhPkg::binReqT                     binReq,
    input  logic                                passEnd,
    output sifhPkg::peakT [sifhPkg::PIXELS-1:0] peak
);
    import sifhPkg::*;

    localparam int ADR_W = $clog2(TOTAL_BINS);

    // ****************************************
    // Bin memory
    // ****************************************
    logic [CNT_W-1:0]      binMem [TOTAL_BINS];
    logic [TOTAL_BINS-1:0] binValid;   // 0 means count reads as zero
    logic [ADR_W-1:0]      reqAdr;

    // Stage 1, read
    binReqT                s1Req;
    logic [CNT_W-1:0]      s1Rd;       // Raw memory word
    logic                  s1Hit;      // Bin written this pass
    logic [ADR_W-1:0]      s1Adr;

    // Stage 2, write and forward
    logic                  s2Valid;
    logic [ADR_W-1:0]      s2Adr;
    logic [CNT_W-1:0]      s2Cnt;

    logic                  fwd;
    logic [CNT_W-1:0]      oldCnt;
    logic [CNT_W-1:0]      incCnt;

    assign reqAdr = {binReq.pixel, binReq.bin};  // Pixel selects the histogram
    assign s1Adr  = {s1Req.pixel, s1Req.bin};

    // Synchronous read like a block RAM
    always_ff @(posedge clk) begin
        s1Rd <= binMem[reqAdr];
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            s1Req <= '0;
            s1Hit <= 1'b0;
        end else begin
            s1Req <= binReq;
            s1Hit <= binValid[reqAdr];
        end
    end

    // ****************************************
    // Increment with forwarding and saturation
    // ****************************************
    always_comb begin
        fwd = s2Valid && (s2Adr == s1Adr);  // Previous write not yet seen by read
        if (fwd)
            oldCnt = s2Cnt;
        else if (s1Hit)
            oldCnt = s1Rd;
        else
            oldCnt = '0;                    // Cleared bin
        incCnt = (oldCnt == {CNT_W{1'b1}}) ? oldCnt : oldCnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (s1Req.valid) begin
            binMem[s1Adr] <= incCnt;
        end
        s2Adr <= s1Adr;
        s2Cnt <= incCnt;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
            s2Valid  <= 1'b0;
            peak     <= '0;
        end else if (passEnd) begin
            binValid <= '0;   // Whole memory cleared in one cycle
            s2Valid  <= 1'b0;
            peak     <= '0;
        end else begin
            s2Valid <= s1Req.valid;
            if (s1Req.valid) begin
                binValid[s1Adr] <= 1'b1;
                // Strictly greater, ties keep the earlier bin
                if (incCnt > peak[s1Req.pixel].count) begin
                    peak[s1Req.pixel].bin   <= s1Req.bin;
                    peak[s1Req.pixel].count <= incCnt;
                end
            end
        end
    end

endmodule

//--- verilog/sifhWindow.sv
/*
 * SiFH sample filter and window unit
 * Bins samples per pass, derives fine windows from coarse peaks, forms results
 */
`timescale 1ns/1ps

module sifhWindow (
    input  logic                                clk,
    input  logic                                combin_res,
    input  logic                                take,
    input  sifhPkg::sampleT                     sample,
    input  sifhPkg::passE                       pass,
    input  logic                                passEnd,
    input  sifhPkg::peakT [sifhPkg::PIXELS-1:0] coarsePeak,
    input  sifhPkg::peakT [sifhPkg::PIXELS-1:0] finePeak,
    output sifhPkg::binReqT                     binReq,
    output sifhPkg::resultT                     result,
    output logic                                resultLoad
);
    import sifhPkg::*;

    windowT [PIXELS-1:0] win;    // Current window per pixel
    logic [NP-1:0]       curStart;
    logic [NP-1:0]       offset;
    logic                inWin;

    // Window start from a coarse peak bin, clipped at both ends
    function automatic windowT calcWindow(input logic [NB-1:0] peakBin);
        logic [NP:0] centre;
        windowT      w;
        centre = (NP+1)'(int'(peakBin) * BINS);
        if (centre < (NP+1)'(HALF_WIN))
            w.start = '0;                                     // Low edge
        else if (centre + (NP+1)'(HALF_WIN) > (NP+1)'(2**NP - 1))
            w.start = NP'(2**NP - BINS);                      // High edge
        else
            w.start = NP'(centre - (NP+1)'(HALF_WIN));
        return w;
    endfunction

    // ****************************************
    // Sample filter
    // ****************************************
    always_comb begin
        curStart = win[sample.pixel].start;
        offset   = sample.timestamp - curStart;  // Shift into window
        inWin    = (sample.timestamp >= curStart) &&
                   ({1'b0, sample.timestamp} <= {1'b0, curStart} + (NP+1)'(BINS - 1));
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binReq <= '0;
        end else begin
            binReq.valid <= take && ((pass == PASS_COARSE) || inWin);  // Drop outside window
            binReq.pixel <= sample.pixel;
            binReq.bin   <= (pass == PASS_COARSE) ? sample.timestamp[NP-1 -: NB]
                                                  : offset[NB-1:0];
            binReq.pass  <= pass;
        end
    end

    // ****************************************
    // Windows and results
    // ****************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            win        <= '0;
            resultLoad <= 1'b0;
        end else begin
            resultLoad <= passEnd && (pass == PASS_FINE);  // One cycle pulse
            if (passEnd && (pass == PASS_COARSE)) begin
                for (int p = 0; p < PIXELS; p++) begin
                    win[p] <= calcWindow(coarsePeak[p].bin);
                end
            end
        end
    end

    // Fine peak back into absolute time
    always_ff @(posedge clk) begin
        if (passEnd && (pass == PASS_FINE)) begin
            for (int p = 0; p < PIXELS; p++) begin
                result[p] <= NP'(finePeak[p].bin) + win[p].start;
            end
        end
    end

endmodule

//--- verilog/wbRegPkg.sv
/*
 * Wishbone classic bus types and register map of the SiFH block
 */

package wbRegPkg;

    localparam int WB_ADR_W = 4;
    localparam int WB_DAT_W = 8;

    // Master to slave
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } wbReqT;

    // Slave to master
    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wbRspT;

    typedef enum logic [WB_ADR_W-1:0] {
        REG_CTRL    = 4'd0,  // Bit 0 enable
        REG_ACQNUM  = 4'd1,  // Acquisitions per pass
        REG_STATUS  = 4'd2,  // Done and frame count
        REG_RESULT0 = 4'd4,
        REG_RESULT1 = 4'd5,
        REG_RESULT2 = 4'd6,
        REG_RESULT3 = 4'd7
    } regAdrE;

endpackage

//--- verilog/sifhPkg.sv
/*
 * SiFH histogram geometry and datapath types
 * Pixel, bin and pass constants plus the structs that move between stages
 */

package sifhPkg;

    // ****************************************
    // Geometry
    // ****************************************
    localparam int NP         = 8;   // Timestamp width
    localparam int NB         = 4;   // Bin address width
    localparam int BINS       = 16;  // Bins per histogram
    localparam int PIXELS     = 4;   // Pixels per frame
    localparam int SAMPLES    = 4;   // Timestamps per pixel per acquisition
    localparam int TOTAL_BINS = 64;  // PIXELS * BINS
    localparam int CNT_W      = 8;   // Bin count width, saturating
    localparam int HALF_WIN   = 8;   // Half the fine window
    localparam int DRAIN      = 3;   // Stall cycles after last sample of a pass

    // ****************************************
    // Types
    // ****************************************
    typedef enum logic {
        PASS_COARSE = 1'b0,
        PASS_FINE   = 1'b1
    } passE;

    // One timestamp tagged with its pixel
    typedef struct packed {
        logic [NP-1:0] timestamp;
        logic [1:0]    pixel;
    } sampleT;

    // Binning request from filter to histogram
    typedef struct packed {
        logic          valid;
        logic [1:0]    pixel;
        logic [NB-1:0] bin;
        passE          pass;
    } binReqT;

    // Running peak of one pixel
    typedef struct packed {
        logic [NB-1:0]    bin;
        logic [CNT_W-1:0] count;
    } peakT;

    // Fine window of one pixel
    typedef struct packed {
        logic [NP-1:0] start;
    } windowT;

    typedef logic [PIXELS-1:0][NP-1:0] resultT;  // Final timestamp per pixel

endpackage
